//--- rtl/axi_rd_pkg.sv
/*
 * AXI read-side types
 * IDs, data, response codes and the flash address word
 */
`default_nettype none

`include "flash_cfg.svh"

package axi_rd_pkg;

    typedef logic [`FLASH_ID_W-1:0] axi_id_t;
    typedef logic [31:0]            axi_data_t;
    typedef logic [1:0]             axi_resp_t;

    localparam axi_resp_t RESP_OKAY = 2'b00;

    // One address word, seen as a byte address or as word index plus offset
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [29:0] word_idx;
            logic [1:0]  byte_off;
        } split;
    } flash_addr_u;

endpackage

`default_nettype wire

//--- rtl/axi_read_port.sv
/*
 * AXI read slave port
 * Accepts one AR at a time, word-aligns it and fetches the data from the sequencer
 */
`timescale 1ns/1ps
`default_nettype none

module axi_read_port (
    input  wire logic                    clk,
    input  wire logic                    nrst,
    input  wire logic                    s_arvalid_i,
    output logic                         s_arready_o,
    input  wire logic [31:0]             s_araddr_i,
    input  wire axi_rd_pkg::axi_id_t     s_arid_i,
    output logic                         s_rvalid_o,
    input  wire logic                    s_rready_i,
    output axi_rd_pkg::axi_data_t        s_rdata_o,
    output axi_rd_pkg::axi_id_t          s_rid_o,
    output axi_rd_pkg::axi_resp_t        s_rresp_o,
    output logic                         s_rlast_o,
    output logic                         rd_req_o,
    output axi_rd_pkg::flash_addr_u      rd_addr_o,
    input  wire logic                    rd_ack_i,
    input  wire axi_rd_pkg::axi_data_t   rd_data_i
);

    import axi_rd_pkg::*;

    logic ar_hs;

    // Idle means no fetch in flight, no pending R and the sequencer released ack
    assign s_arready_o = !rd_req_o && !s_rvalid_o && !rd_ack_i;
    assign ar_hs       = s_arvalid_i && s_arready_o;

    // Single beats only, always OKAY
    assign s_rresp_o = RESP_OKAY;
    assign s_rlast_o = 1'b1;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            rd_req_o   <= 1'b0;
            s_rvalid_o <= 1'b0;
        end else if (ar_hs) begin
            rd_req_o <= 1'b1;
        end else if (rd_req_o && rd_ack_i) begin
            rd_req_o   <= 1'b0;
            s_rvalid_o <= 1'b1;
        end else if (s_rvalid_o && s_rready_i) begin
            s_rvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            s_rid_o                  <= s_arid_i;
            rd_addr_o.split.word_idx <= s_araddr_i[31:2];
            rd_addr_o.split.byte_off <= 2'b00;
        end
        if (rd_req_o && rd_ack_i) begin
            s_rdata_o <= rd_data_i;
        end
    end

    a_r_hold: assert property (@(posedge clk) disable iff (!nrst)
        s_rvalid_o && !s_rready_i |=>
            s_rvalid_o && $stable(s_rdata_o) && $stable(s_rid_o));

    // Four-phase rule, req stays up until the sequencer acknowledges
    a_req_until_ack: assert property (@(posedge clk) disable iff (!nrst)
        rd_req_o && !rd_ack_i |=> rd_req_o);

endmodule

`default_nettype wire

//--- rtl/flash_cfg.svh
/*
 * Quad-I/O flash read controller configuration
 * Build-time constants shared by the RTL and the testbench
 */
`ifndef FLASH_CFG_SVH
`define FLASH_CFG_SVH

// AXI transaction ID width
`define FLASH_ID_W 4

// Dummy sck cycles between mode and data
`define FLASH_DUMMY_CYCLES 4

// Quad-I/O fast read opcode
`define FLASH_READ_CMD 8'hEB

// Width of the sck divider setting
`define FLASH_CLK_DIV_W 4

`endif

//--- rtl/flash_clk_gen.sv
/*
 * Serial flash clock generator
 * Divides clk down to sck and flags each coming sck edge one clk early
 */
`timescale 1ns/1ps
`default_nettype none

`include "flash_cfg.svh"

module flash_clk_gen (
    input  wire logic                        clk,
    input  wire logic                        nrst,
    input  wire logic [`FLASH_CLK_DIV_W-1:0] clk_div_i,
    input  wire logic                        sck_en_i,
    output logic                             sck_o,
    output logic                             sck_rise_o,
    output logic                             sck_fall_o
);

    logic [`FLASH_CLK_DIV_W-1:0] half_cnt;
    logic                        half_end;

    // Compare with >= so a divider change mid-phase cannot wrap the counter
    assign half_end = (half_cnt >= clk_div_i);

    // Rise only while enabled, a pending fall always completes
    assign sck_rise_o = sck_en_i && !sck_o && half_end;
    assign sck_fall_o = sck_o && half_end;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            half_cnt <= '0;
            sck_o    <= 1'b0;
        end else if (sck_en_i || sck_o) begin
            if (half_end) begin
                half_cnt <= '0;
                sck_o    <= !sck_o;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end else begin
            // Parked low, next enable starts a full low phase
            half_cnt <= '0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/flash_read_ctrl.sv
/*
 * Read-only quad-I/O flash controller, top level
 * AXI read port, flash sequencer, sck divider and dq pads
 */
`timescale 1ns/1ps
`default_nettype none

`include "flash_cfg.svh"

module flash_read_ctrl (
    input  wire logic                        clk,
    input  wire logic                        nrst,
    input  wire logic [`FLASH_CLK_DIV_W-1:0] clk_div_i,
    input  wire logic                        s_arvalid_i,
    output logic                             s_arready_o,
    input  wire logic [31:0]                 s_araddr_i,
    input  wire axi_rd_pkg::axi_id_t         s_arid_i,
    output logic                             s_rvalid_o,
    input  wire logic                        s_rready_i,
    output axi_rd_pkg::axi_data_t            s_rdata_o,
    output axi_rd_pkg::axi_id_t              s_rid_o,
    output axi_rd_pkg::axi_resp_t            s_rresp_o,
    output logic                             s_rlast_o,
    output logic                             flash_sck_o,
    output logic                             flash_cs_n_o,
    inout  wire logic [3:0]                  flash_dq_io
);

    import axi_rd_pkg::*;
    import qspi_pkg::*;

    logic        rd_req;
    flash_addr_u rd_addr;
    logic        rd_ack;
    axi_data_t   rd_data;
    logic        sck_en;
    logic        sck_rise;
    logic        sck_fall;
    nibble_t     dq_out;
    nibble_t     dq_in;
    logic        dq_oe;

    // Quad pads
    assign flash_dq_io = dq_oe ? dq_out : 4'bzzzz;
    assign dq_in       = flash_dq_io;

    axi_read_port i_axi_read_port (
        .clk         (clk),
        .nrst        (nrst),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_araddr_i  (s_araddr_i),
        .s_arid_i    (s_arid_i),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .s_rdata_o   (s_rdata_o),
        .s_rid_o     (s_rid_o),
        .s_rresp_o   (s_rresp_o),
        .s_rlast_o   (s_rlast_o),
        .rd_req_o    (rd_req),
        .rd_addr_o   (rd_addr),
        .rd_ack_i    (rd_ack),
        .rd_data_i   (rd_data)
    );

    qspi_read_seq i_qspi_read_seq (
        .clk        (clk),
        .nrst       (nrst),
        .rd_req_i   (rd_req),
        .rd_addr_i  (rd_addr),
        .rd_ack_o   (rd_ack),
        .rd_data_o  (rd_data),
        .sck_rise_i (sck_rise),
        .sck_fall_i (sck_fall),
        .sck_en_o   (sck_en),
        .cs_n_o     (flash_cs_n_o),
        .dq_o       (dq_out),
        .dq_oe_o    (dq_oe),
        .dq_i       (dq_in)
    );

    flash_clk_gen i_flash_clk_gen (
        .clk        (clk),
        .nrst       (nrst),
        .clk_div_i  (clk_div_i),
        .sck_en_i   (sck_en),
        .sck_o      (flash_sck_o),
        .sck_rise_o (sck_rise),
        .sck_fall_o (sck_fall)
    );

endmodule

`default_nettype wire

//--- rtl/qspi_pkg.sv
/*
 * Flash-side types
 * Sequencer phases and the quad data nibble
 */
`default_nettype none

package qspi_pkg;

    // One transfer on dq[3:0]
    typedef logic [3:0] nibble_t;

    // Order matters, the sequencer steps through it by increment
    typedef enum logic [2:0] {
        IDLE,
        CMD,
        ADDR,
        MODE,
        DUMMY,
        DATA,
        DONE
    } qspi_phase_t;

endpackage

`default_nettype wire

//--- rtl/qspi_read_seq.sv
/*
 * Quad-I/O fast read sequencer
 * Sends command, address, mode and dummy cycles, then assembles one data word
 */
`timescale 1ns/1ps
`default_nettype none

`include "flash_cfg.svh"

module qspi_read_seq (
    input  wire logic                   clk,
    input  wire logic                   nrst,
    input  wire logic                   rd_req_i,
    input  wire axi_rd_pkg::flash_addr_u rd_addr_i,
    output logic                        rd_ack_o,
    output axi_rd_pkg::axi_data_t       rd_data_o,
    input  wire logic                   sck_rise_i,
    input  wire logic                   sck_fall_i,
    output logic                        sck_en_o,
    output logic                        cs_n_o,
    output qspi_pkg::nibble_t           dq_o,
    output logic                        dq_oe_o,
    input  wire qspi_pkg::nibble_t      dq_i
);

    import qspi_pkg::*;

    localparam logic [7:0] READ_CMD = `FLASH_READ_CMD;

    qspi_phase_t phase;
    logic [3:0]  bit_cnt;
    logic [3:0]  last_cnt;
    nibble_t     next_nib;
    logic        drive_phase;

    // Sck runs through every active phase
    assign sck_en_o = (phase != IDLE) && (phase != DONE);

    // Host drives dq during command, address and mode
    assign drive_phase = (phase == CMD) || (phase == ADDR) || (phase == MODE);

    // Last cycle index of each phase
    always_comb begin
        case (phase)
            CMD, ADDR, DATA: last_cnt = 4'd7;
            MODE:            last_cnt = 4'd1;
            DUMMY:           last_cnt = 4'(`FLASH_DUMMY_CYCLES - 1);
            default:         last_cnt = 4'd0;
        endcase
    end

    // Nibble for the current cycle, MSB of command and high address nibble first
    always_comb begin
        case (phase)
            CMD:     next_nib = {3'b000, READ_CMD[~bit_cnt[2:0]]};
            ADDR:    next_nib = rd_addr_i.raw[{~bit_cnt[2:0], 2'b00} +: 4];
            default: next_nib = 4'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            phase    <= IDLE;
            bit_cnt  <= '0;
            cs_n_o   <= 1'b1;
            dq_oe_o  <= 1'b0;
            rd_ack_o <= 1'b0;
        end else begin
            case (phase)
                IDLE: begin
                    if (rd_req_i && !rd_ack_o) begin
                        phase   <= CMD;
                        bit_cnt <= '0;
                        cs_n_o  <= 1'b0;
                        dq_oe_o <= 1'b1;
                    end
                end
                DONE: begin
                    if (!rd_ack_o) begin
                        // Release cs_n with the final sck fall
                        if (sck_fall_i) begin
                            cs_n_o   <= 1'b1;
                            rd_ack_o <= 1'b1;
                        end
                    end else if (!rd_req_i) begin
                        rd_ack_o <= 1'b0;
                        phase    <= IDLE;
                    end
                end
                default: begin
                    // A cycle completes on the rising edge
                    if (sck_rise_i) begin
                        if (bit_cnt == last_cnt) begin
                            bit_cnt <= '0;
                            phase   <= qspi_phase_t'(phase + 3'd1);
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                    if (sck_fall_i) begin
                        dq_oe_o <= drive_phase;
                    end
                end
            endcase
        end
    end

    // Pin data and captured word
    always_ff @(posedge clk) begin
        if (phase == IDLE) begin
            dq_o <= {3'b000, READ_CMD[7]};
        end else if (sck_fall_i && sck_en_o) begin
            dq_o <= next_nib;
        end

        // Byte k goes to bits 8k+7:8k, high nibble arrives first
        if (sck_rise_i && phase == DATA) begin
            rd_data_o[{bit_cnt[2:1], ~bit_cnt[0], 2'b00} +: 4] <= dq_i;
        end
    end

    a_cs_idle: assert property (@(posedge clk) disable iff (!nrst)
        phase == IDLE |-> cs_n_o);

    // Turnaround must be finished before the flash drives data
    a_no_drive_in_data: assert property (@(posedge clk) disable iff (!nrst)
        phase == DATA |-> !dq_oe_o);

    a_addr_stable: assert property (@(posedge clk) disable iff (!nrst)
        (rd_req_i && !rd_ack_o) [*2] |-> $stable(rd_addr_i));

endmodule

`default_nettype wire

//--- sim.f
+incdir+rtl
rtl/axi_rd_pkg.sv
rtl/qspi_pkg.sv
rtl/flash_clk_gen.sv
rtl/qspi_read_seq.sv
rtl/axi_read_port.sv
rtl/flash_read_ctrl.sv
tests/qspi_flash_model.sv
tests/tb_flash_read_ctrl.sv

//--- tests/qspi_flash_model.sv
/*
 * Behavioral quad-I/O serial flash
 * Answers the quad fast-read command from a fixed 256-byte pattern
 */
`timescale 1ns/1ps
`default_nettype none

`include "flash_cfg.svh"

module qspi_flash_model (
    input  wire logic       sck_i,
    input  wire logic       cs_n_i,
    inout  wire logic [3:0] dq_io,
    output int              cmd_errors_o
);

    // Rising edges before the first data nibble
    localparam int DATA_START = 8 + 8 + 2 + `FLASH_DUMMY_CYCLES;

    logic [7:0]  mem [256];
    logic [7:0]  cmd;
    logic [31:0] addr;
    logic [3:0]  dq_drv;
    logic        dq_en;
    int          rises;
    int          nib;
    int          idx;

    assign dq_io = dq_en ? dq_drv : 4'bzzzz;

    initial begin
        for (idx = 0; idx < 256; idx++) begin
            mem[idx] = 8'(idx) ^ 8'hA5;
        end
        dq_en        = 1'b0;
        dq_drv       = '0;
        rises        = 0;
        cmd_errors_o = 0;
    end

    // Every falling cs_n starts a new command
    always @(negedge cs_n_i) begin
        rises = 0;
        cmd   = '0;
        addr  = '0;
    end

    always @(posedge cs_n_i) begin
        dq_en = 1'b0;
    end

    // Host bits are sampled on the rising sck edge
    always @(posedge sck_i) begin
        if (!cs_n_i) begin
            if (rises < 8) begin
                cmd = {cmd[6:0], dq_io[0]};
            end else if (rises < 16) begin
                addr = {addr[27:0], dq_io};
            end
            rises = rises + 1;
            if (rises == 8 && cmd !== `FLASH_READ_CMD) begin
                cmd_errors_o = cmd_errors_o + 1;
                $display("Flash model received command %02h instead of %02h at %0d ns",
                         cmd, `FLASH_READ_CMD, $time);
            end
        end
    end

    // Data leaves after the falling edge, high nibble of each byte first
    always @(negedge sck_i) begin
        if (!cs_n_i && rises >= DATA_START && rises < DATA_START + 8) begin
            nib    = rises - DATA_START;
            dq_drv = nib[0] ? mem[addr[7:0] + 8'(nib >> 1)][3:0]
                            : mem[addr[7:0] + 8'(nib >> 1)][7:4];
            dq_en  = 1'b1;
        end else begin
            dq_en = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_flash_read_ctrl.sv
/*
 * Testbench for the quad-I/O flash read controller
 * Directed AXI reads against the behavioral flash
 */
`timescale 1ns/1ps
`default_nettype none

`include "flash_cfg.svh"

module tb_flash_read_ctrl;

    import axi_rd_pkg::*;

    localparam int TIMEOUT = 2000;

    logic                        clk;
    logic                        nrst;
    logic [`FLASH_CLK_DIV_W-1:0] clk_div_i;
    logic                        s_arvalid_i;
    logic                        s_arready_o;
    logic [31:0]                 s_araddr_i;
    axi_id_t                     s_arid_i;
    logic                        s_rvalid_o;
    logic                        s_rready_i;
    axi_data_t                   s_rdata_o;
    axi_id_t                     s_rid_o;
    axi_resp_t                   s_rresp_o;
    logic                        s_rlast_o;
    logic                        flash_sck_o;
    logic                        flash_cs_n_o;
    wire logic [3:0]             flash_dq_io;
    int                          cmd_errors;
    int                          errors;
    int                          checks;
    int                          seed;

    flash_read_ctrl i_dut (.*);

    qspi_flash_model i_flash_model (
        .sck_i        (flash_sck_o),
        .cs_n_i       (flash_cs_n_o),
        .dq_io        (flash_dq_io),
        .cmd_errors_o (cmd_errors)
    );

    always #50 clk = !clk;

    // Pattern byte at a is a[7:0] ^ A5, little-endian within the word
    function automatic axi_data_t expected_word(input logic [31:0] addr);
        axi_data_t word;
        int        k;
        for (k = 0; k < 4; k++) begin
            word[8*k +: 8] = ({addr[7:2], 2'b00} + 8'(k)) ^ 8'hA5;
        end
        return word;
    endfunction

    task automatic check_data(input axi_data_t got, input axi_data_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns: %s, got %08h, expected %08h", $time, msg, got, exp);
        end
    endtask

    task automatic check_id(input axi_id_t got, input axi_id_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns: %s, got %0h, expected %0h", $time, msg, got, exp);
        end
    endtask

    task automatic check_resp(input axi_resp_t got, input axi_resp_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns: %s, got %0d, expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns: %s, got %b, expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic print_result(input string name, input int first_err);
        $display("%-24s %0d errors", name, errors - first_err);
    endtask

    // One AR handshake, then wait for rvalid; lat counts clk cycles in between
    task automatic do_read(input logic [31:0] addr, input axi_id_t id,
                           output axi_data_t data, output axi_id_t rid, output int lat);
        int n;
        data = 'x;
        rid  = 'x;
        lat  = -1;
        @(posedge clk);
        s_arvalid_i <= 1'b1;
        s_araddr_i  <= addr;
        s_arid_i    <= id;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!s_arready_o && n < TIMEOUT);
        s_arvalid_i <= 1'b0;
        if (!s_arready_o) begin
            errors++;
            $display("Timed out waiting for arready, address %08h", addr);
            return;
        end
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!s_rvalid_o && n < TIMEOUT);
        if (!s_rvalid_o) begin
            errors++;
            $display("Timed out waiting for rvalid, address %08h", addr);
            return;
        end
        data = s_rdata_o;
        rid  = s_rid_o;
        lat  = n;
        check_resp(s_rresp_o, RESP_OKAY, "rresp");
        check_bit(s_rlast_o, 1'b1, "rlast");
    endtask

    task automatic verify_reset_state();
        int e0;
        e0 = errors;
        check_bit(flash_cs_n_o, 1'b1, "cs_n after reset");
        check_bit(flash_sck_o, 1'b0, "sck after reset");
        check_bit(s_rvalid_o, 1'b0, "rvalid after reset");
        print_result("reset state", e0);
    endtask

    task automatic read_aligned_word();
        int        e0;
        int        lat;
        axi_data_t data;
        axi_id_t   rid;
        e0 = errors;
        do_read(32'h0000_0040, 4'h3, data, rid, lat);
        check_data(data, expected_word(32'h0000_0040), "aligned read");
        check_id(rid, 4'h3, "aligned read id");
        print_result("aligned read", e0);
    endtask

    task automatic read_unaligned_word();
        int        e0;
        int        lat;
        axi_data_t ref_data;
        axi_data_t data;
        axi_id_t   rid;
        e0 = errors;
        do_read(32'h0000_009C, 4'h0, ref_data, rid, lat);
        do_read(32'h0000_009E, 4'hB, data, rid, lat);
        check_data(data, ref_data, "unaligned vs aligned read");
        check_data(data, expected_word(32'h0000_009C), "unaligned read");
        check_id(rid, 4'hB, "unaligned read id");
        print_result("unaligned read", e0);
    endtask

    task automatic hold_under_backpressure();
        int        e0;
        int        lat;
        int        hold;
        int        i;
        int        n;
        axi_data_t data;
        axi_id_t   rid;
        e0   = errors;
        hold = 3 + ({$random(seed)} % 18);
        s_rready_i <= 1'b0;
        do_read(32'h0000_0010, 4'h5, data, rid, lat);
        check_data(data, expected_word(32'h0000_0010), "back-pressure read");
        check_id(rid, 4'h5, "back-pressure read id");
        // A second request waits while R is stalled
        s_arvalid_i <= 1'b1;
        s_araddr_i  <= 32'h0000_0024;
        s_arid_i    <= 4'h6;
        for (i = 0; i < hold; i++) begin
            @(posedge clk);
            check_bit(s_rvalid_o, 1'b1, "rvalid held");
            check_data(s_rdata_o, expected_word(32'h0000_0010), "rdata held");
            check_id(s_rid_o, 4'h5, "rid held");
            check_bit(s_arready_o, 1'b0, "arready under back-pressure");
            check_bit(flash_cs_n_o, 1'b1, "cs_n under back-pressure");
        end
        s_rready_i <= 1'b1;
        // R handshake on the next edge, the waiting AR one edge later
        @(posedge clk);
        check_bit(s_rvalid_o, 1'b1, "rvalid at handshake");
        @(posedge clk);
        check_bit(s_rvalid_o, 1'b0, "rvalid after handshake");
        check_bit(s_arready_o, 1'b1, "arready after R handshake");
        s_arvalid_i <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!s_rvalid_o && n < TIMEOUT);
        if (!s_rvalid_o) begin
            errors++;
            $display("Timed out waiting for rvalid of the read held off by back-pressure");
        end
        check_data(s_rdata_o, expected_word(32'h0000_0024), "read after back-pressure");
        check_id(s_rid_o, 4'h6, "id after back-pressure");
        print_result("back-pressure", e0);
    endtask

    task automatic sweep_divider();
        int                          e0;
        int                          i;
        int                          lat [3];
        logic [`FLASH_CLK_DIV_W-1:0] divs [3];
        axi_data_t                   data;
        axi_id_t                     rid;
        e0 = errors;
        divs = '{4'd0, 4'd3, 4'd7};
        for (i = 0; i < 3; i++) begin
            clk_div_i <= divs[i];
            do_read(32'h0000_00E4, axi_id_t'(i), data, rid, lat[i]);
            check_data(data, expected_word(32'h0000_00E4), "divider read");
        end
        check_bit(lat[1] > lat[0], 1'b1, "divider 3 slower than 0");
        check_bit(lat[2] > lat[1], 1'b1, "divider 7 slower than 3");
        clk_div_i <= 4'd1;
        print_result("divider sweep", e0);
    endtask

    task automatic run_back_to_back();
        int          e0;
        int          i;
        int          lat;
        logic [31:0] addr;
        axi_id_t     id;
        axi_data_t   data;
        axi_id_t     rid;
        e0 = errors;
        for (i = 0; i < 8; i++) begin
            addr = $random(seed);
            id   = axi_id_t'($random(seed));
            do_read(addr, id, data, rid, lat);
            check_data(data, expected_word(addr), "back-to-back data");
            check_id(rid, id, "back-to-back id");
        end
        print_result("back-to-back reads", e0);
    endtask

    initial begin
        clk         = 1'b0;
        nrst        = 1'b0;
        clk_div_i   = 4'd1;
        s_arvalid_i = 1'b0;
        s_araddr_i  = '0;
        s_arid_i    = '0;
        s_rready_i  = 1'b1;
        errors      = 0;
        checks      = 0;
        seed        = 32'h0175_75ea;
        repeat (2) @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);

        verify_reset_state();
        read_aligned_word();
        read_unaligned_word();
        hold_under_backpressure();
        sweep_divider();
        run_back_to_back();

        errors += cmd_errors;
        $display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
